/* alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module alu (
	input  logic [`XLEN-1:0]    op_a,
	input  logic [`XLEN-1:0]    op_b,      // rs2 value for branches
	input  rv_core_pkg::alu_op_e alu_op,
	output logic [`XLEN-1:0]    res,
	output logic                zero,      // op_a equals op_b
	output logic                less       // Signed op_a below op_b
);
	import rv_core_pkg::*;

	logic less_u;

	// Flags for the branch decision in EXE
	assign zero   = (op_a == op_b);
	assign less   = ($signed(op_a) < $signed(op_b));
	assign less_u = (op_a < op_b);

	always_comb begin
		case (alu_op)
			ALU_ADD:    res = op_a + op_b;
			ALU_SUB:    res = op_a - op_b;
			ALU_AND:    res = op_a & op_b;
			ALU_OR:     res = op_a | op_b;
			ALU_XOR:    res = op_a ^ op_b;
			ALU_SLT:    res = `XLEN'(less);     // Zero-extended flag
			ALU_SLTU:   res = `XLEN'(less_u);
			ALU_PASS_B: res = op_b;             // LUI
			default:    res = op_a + op_b;
		endcase
	end

endmodule

`default_nettype wire

/* core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,        // Fetch enable
	input  logic                 prog_we,
	input  logic [`IMEM_AW-1:0]  prog_addr,
	input  logic [`XLEN-1:0]     prog_data,
	output rv_core_pkg::retire_t retire      // Registered MEM/WB output
);
	import rv_core_pkg::*;

	logic [`PC_W-1:0]   pc_q, pc_d, pc_plus4;
	logic [`XLEN-1:0]   if_inst;
	if_id_t             if_id_d, if_id_q;
	logic [`REG_AW-1:0] id_rs1, id_rs2;
	ctrl_t              id_ctrl;
	logic [`XLEN-1:0]   id_imm, rf_a, rf_b, id_val_a, id_val_b;
	logic [`PC_W-1:0]   id_target;
	logic               id_jump;
	id_exe_t            id_exe_d, id_exe_q;
	logic [`XLEN-1:0]   alu_b, alu_res;
	logic               alu_zero, alu_less, br_cond, branch_taken;
	exe_mem_t           exe_mem_d, exe_mem_q;
	mem_wb_t            mem_wb_q;
	logic [`XLEN-1:0]   exe_wdata, mem_wdata, wb_wdata;
	fwd_sel_e           fwd_a, fwd_b;
	logic               if_id_flush, id_exe_flush;
	pc_sel_e            pc_sel;

	// Value a stage would write back
	function automatic logic [`XLEN-1:0] wb_data(input exe_mem_t s);
		return (s.wb_sel == WB_PC4) ? `XLEN'(s.pc4) : s.alu_res;
	endfunction

	function automatic logic [`XLEN-1:0] fwd_val(input fwd_sel_e sel,
		input logic [`XLEN-1:0] rf_val, input logic [`XLEN-1:0] exe_val,
		input logic [`XLEN-1:0] mem_val, input logic [`XLEN-1:0] wb_val);
		case (sel)
			FWD_EXE: return exe_val;
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	// IF
	assign pc_plus4 = pc_q + `PC_W'(4);

	always_comb begin
		case (pc_sel)
			PC_BRANCH: pc_d = id_exe_q.branch_target;
			PC_JUMP:   pc_d = id_target;
			PC_PLUS4:  pc_d = pc_plus4;
			default:   pc_d = pc_q;         // Held while run is low
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_d;
		end
	end

	instmem instmem_i (
		.clk        (clk),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.fetch_addr (pc_q[`IMEM_AW+1:2]),
		.inst       (if_inst)
	);

	always_comb begin
		if_id_d.valid = 1'b1;       // Dropped by flush when needed
		if_id_d.pc    = pc_q;
		if_id_d.inst  = if_inst;
	end

	stage_reg #(.payload_t(if_id_t)) if_id_reg (
		.clk(clk), .rst_n(rst_n), .flush(if_id_flush), .d(if_id_d), .q(if_id_q)
	);

	// ID
	assign id_rs1 = if_id_q.inst[19:15];
	assign id_rs2 = if_id_q.inst[24:20];

	decoder decoder_i (.inst(if_id_q.inst), .ctrl(id_ctrl), .imm(id_imm));

	regfile regfile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (mem_wb_q.valid && mem_wb_q.wr_en),
		.wr_addr  (mem_wb_q.rd),
		.wr_data  (wb_wdata),
		.rs1_addr (id_rs1),
		.rs2_addr (id_rs2),
		.rs1_data (rf_a),
		.rs2_data (rf_b)
	);

	hazard_unit hazard_unit_i (
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.id_ctrl      (id_ctrl),
		.exe_q        (id_exe_q),
		.mem_q        (exe_mem_q),
		.wb_q         (mem_wb_q),
		.run          (run),
		.branch_taken (branch_taken),
		.id_jump      (id_jump),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.if_id_flush  (if_id_flush),
		.id_exe_flush (id_exe_flush),
		.pc_sel       (pc_sel)
	);

	assign id_val_a  = fwd_val(fwd_a, rf_a, exe_wdata, mem_wdata, wb_wdata);
	assign id_val_b  = fwd_val(fwd_b, rf_b, exe_wdata, mem_wdata, wb_wdata);
	assign id_target = if_id_q.pc + id_imm[`PC_W-1:0];     // JAL and branch target
	assign id_jump   = if_id_q.valid && id_ctrl.is_jump;

	always_comb begin
		id_exe_d.valid         = if_id_q.valid;
		id_exe_d.pc            = if_id_q.pc;
		id_exe_d.pc4           = if_id_q.pc + `PC_W'(4);
		id_exe_d.rd            = if_id_q.inst[11:7];
		id_exe_d.ctrl          = id_ctrl;
		id_exe_d.op_a          = id_ctrl.uses_rs1 ? id_val_a : `XLEN'(if_id_q.pc);   // PC for JAL and LUI
		id_exe_d.op_b          = id_ctrl.use_imm_b ? id_imm : id_val_b;
		id_exe_d.rs2_val       = id_val_b;
		id_exe_d.branch_target = id_target;
	end

	stage_reg #(.payload_t(id_exe_t)) id_exe_reg (
		.clk(clk), .rst_n(rst_n), .flush(id_exe_flush), .d(id_exe_d), .q(id_exe_q)
	);

	// EXE
	assign alu_b = (id_exe_q.ctrl.br_kind != BR_NONE) ? id_exe_q.rs2_val : id_exe_q.op_b;

	alu alu_i (
		.op_a   (id_exe_q.op_a),
		.op_b   (alu_b),
		.alu_op (id_exe_q.ctrl.alu_op),
		.res    (alu_res),
		.zero   (alu_zero),
		.less   (alu_less)
	);

	always_comb begin
		case (id_exe_q.ctrl.br_kind)
			BR_EQ:   br_cond = alu_zero;
			BR_NE:   br_cond = !alu_zero;
			BR_LT:   br_cond = alu_less;
			BR_GE:   br_cond = !alu_less;
			default: br_cond = 1'b0;
		endcase
		branch_taken = id_exe_q.valid && br_cond;
	end

	always_comb begin
		exe_mem_d.valid   = id_exe_q.valid;
		exe_mem_d.rd      = id_exe_q.rd;
		exe_mem_d.wr_en   = id_exe_q.ctrl.wr_en;
		exe_mem_d.wb_sel  = id_exe_q.ctrl.wb_sel;
		exe_mem_d.alu_res = alu_res;
		exe_mem_d.pc4     = id_exe_q.pc4;
	end

	stage_reg #(.payload_t(exe_mem_t)) exe_mem_reg (
		.clk(clk), .rst_n(rst_n), .flush(1'b0), .d(exe_mem_d), .q(exe_mem_q)
	);

	// MEM is only a stage of delay
	stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
		.clk(clk), .rst_n(rst_n), .flush(1'b0), .d(exe_mem_q), .q(mem_wb_q)
	);

	// Forwarding sources and WB
	assign exe_wdata = wb_data(exe_mem_d);
	assign mem_wdata = wb_data(exe_mem_q);
	assign wb_wdata  = wb_data(mem_wb_q);

	always_comb begin
		retire.valid = mem_wb_q.valid && mem_wb_q.wr_en && mem_wb_q.rd != '0;
		retire.rd    = mem_wb_q.rd;
		retire.data  = wb_wdata;
		retire.pc    = mem_wb_q.pc4 - `PC_W'(4);
	end

	// Both younger stages come up empty after a taken branch
	a_branch_bubbles: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |=> !if_id_q.valid && !id_exe_q.valid);

endmodule

`default_nettype wire

/* core_golden.txt */
# P word_addr instruction_word | T test_name | R rd data pc, all fields hex
# R records follow program order; text after the fields is ignored
P 00 00500093 addi x1, x0, 5
P 01 FFD00113 addi x2, x0, -3
P 02 123451B7 lui x3, 0x12345
P 03 00F0C213 xori x4, x1, 0xf
P 04 00012293 slti x5, x2, 0
P 05 0F017313 andi x6, x2, 0xf0
P 06 6781E393 ori x7, x3, 0x678
P 07 00708433 add x8, x1, x7
P 08 401404B3 sub x9, x8, x1
P 09 0084C533 xor x10, x9, x8
P 0A 00A475B3 and x11, x8, x10
P 0B 0025E633 or x12, x11, x2
P 0C 001126B3 slt x13, x2, x1
P 0D 00113733 sltu x14, x2, x1
P 0E 00108663 beq x1, x1, +12 taken
P 0F 00100793 addi x15, x0, 1 skipped
P 10 00200793 addi x15, x0, 2 skipped
P 11 00209663 bne x1, x2, +12 taken
P 12 00300793 addi x15, x0, 3 skipped
P 13 00400793 addi x15, x0, 4 skipped
P 14 00114663 blt x2, x1, +12 taken
P 15 00500793 addi x15, x0, 5 skipped
P 16 00600793 addi x15, x0, 6 skipped
P 17 0020D663 bge x1, x2, +12 taken
P 18 00100793 addi x15, x0, 1 skipped
P 19 00200793 addi x15, x0, 2 skipped
P 1A 00208463 beq x1, x2, +8 not taken
P 1B 00700793 addi x15, x0, 7
P 1C 0080086F jal x16, +8
P 1D 00900893 addi x17, x0, 9 skipped
P 1E 00180913 addi x18, x16, 1
P 1F 00708013 addi x0, x1, 7
P 20 01100993 addi x19, x0, 0x11
T imm
R 01 00000005 000
R 02 FFFFFFFD 004
R 03 12345000 008
R 04 0000000A 00C
R 05 00000001 010
R 06 000000F0 014
R 07 12345678 018
T fwd
R 08 1234567D 01C
R 09 12345678 020
R 0A 00000005 024
R 0B 00000005 028
R 0C FFFFFFFD 02C
R 0D 00000001 030
R 0E 00000000 034
T branch
R 0F 00000007 06C
T jal
R 10 00000074 070
R 12 00000075 078
T x0
R 13 00000011 080

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module decoder (
	input  logic [`XLEN-1:0] inst,
	output rv_core_pkg::ctrl_t ctrl,
	output logic [`XLEN-1:0] imm
);
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       arith_ok;       // funct3 names a supported operation
	alu_op_e    arith_op;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Shared by register and immediate forms
	always_comb begin
		arith_ok = 1'b1;
		case (funct3)
			3'b000: arith_op = (opcode == `OP_ALU && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b110: arith_op = ALU_OR;
			3'b111: arith_op = ALU_AND;
			default: begin      // Shifts are not in the subset
				arith_op = ALU_ADD;
				arith_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl = '0;      // Bubble by default
		case (opcode)
			`OP_ALU: begin
				ctrl.alu_op   = arith_op;
				ctrl.wr_en    = arith_ok;
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;
			end
			`OP_ALUI: begin
				ctrl.alu_op    = arith_op;
				ctrl.use_imm_b = 1'b1;
				ctrl.wr_en     = arith_ok;
				ctrl.uses_rs1  = 1'b1;
			end
			`OP_LUI: begin
				ctrl.alu_op    = ALU_PASS_B;    // Upper immediate straight through
				ctrl.use_imm_b = 1'b1;
				ctrl.wr_en     = 1'b1;
			end
			`OP_JAL: begin
				ctrl.is_jump = 1'b1;
				ctrl.wr_en   = 1'b1;
				ctrl.wb_sel  = WB_PC4;          // Link value
			end
			`OP_BRANCH: begin
				ctrl.alu_op   = ALU_SUB;
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;
				case (funct3)
					`F3_BEQ: ctrl.br_kind = BR_EQ;
					`F3_BNE: ctrl.br_kind = BR_NE;
					`F3_BLT: ctrl.br_kind = BR_LT;
					`F3_BGE: ctrl.br_kind = BR_GE;
					default: ctrl.br_kind = BR_NONE;    // Unsigned forms dropped
				endcase
			end
			default: ;
		endcase
	end

	// Immediate formats
	always_comb begin
		case (opcode)
			`OP_LUI:    imm = {inst[31:12], 12'b0};
			`OP_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			`OP_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			default:    imm = {{20{inst[31]}}, inst[31:20]};   // I-type
		endcase
	end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module hazard_unit (
	input  logic [`REG_AW-1:0]     id_rs1,
	input  logic [`REG_AW-1:0]     id_rs2,
	input  rv_core_pkg::ctrl_t     id_ctrl,
	input  rv_core_pkg::id_exe_t   exe_q,
	input  rv_core_pkg::exe_mem_t  mem_q,
	input  rv_core_pkg::mem_wb_t   wb_q,
	input  logic                   run,
	input  logic                   branch_taken,   // Resolved in EXE
	input  logic                   id_jump,        // Valid JAL in ID
	output rv_core_pkg::fwd_sel_e  fwd_a,
	output rv_core_pkg::fwd_sel_e  fwd_b,
	output logic                   if_id_flush,
	output logic                   id_exe_flush,
	output rv_core_pkg::pc_sel_e   pc_sel
);
	import rv_core_pkg::*;

	// Youngest writer of rs wins
	function automatic fwd_sel_e pick(input logic used, input logic [`REG_AW-1:0] rs);
		if (!used || rs == '0) begin
			return FWD_RF;      // x0 or operand not read
		end else if (exe_q.valid && exe_q.ctrl.wr_en && exe_q.rd == rs) begin
			return FWD_EXE;
		end else if (mem_q.valid && mem_q.wr_en && mem_q.rd == rs) begin
			return FWD_MEM;
		end else if (wb_q.valid && wb_q.wr_en && wb_q.rd == rs) begin
			return FWD_WB;
		end
		return FWD_RF;
	endfunction

	always_comb begin
		fwd_a = pick(id_ctrl.uses_rs1, id_rs1);
		fwd_b = pick(id_ctrl.uses_rs2, id_rs2);
	end

	// Redirect priority branch, then jump, then run
	always_comb begin
		if_id_flush  = 1'b0;
		id_exe_flush = 1'b0;
		pc_sel       = PC_PLUS4;
		if (branch_taken) begin
			pc_sel       = PC_BRANCH;
			if_id_flush  = 1'b1;
			id_exe_flush = 1'b1;    // Two younger instructions dropped
		end else if (id_jump) begin
			pc_sel      = PC_JUMP;
			if_id_flush = 1'b1;     // Fall-through fetch dropped
		end else if (!run) begin
			pc_sel      = PC_HOLD;
			if_id_flush = 1'b1;     // Feed bubbles while loading
		end
	end

endmodule

`default_nettype wire

/* instmem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module instmem (
	input  logic                clk,
	input  logic                prog_we,        // One word per strobe
	input  logic [`IMEM_AW-1:0] prog_addr,
	input  logic [`XLEN-1:0]    prog_data,
	input  logic [`IMEM_AW-1:0] fetch_addr,     // Word address from PC
	output logic [`XLEN-1:0]    inst
);

	// Empty words execute as NOPs
	logic [`XLEN-1:0] mem [`IMEM_WORDS] = '{default: `NOP_INST};

	// Program port
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Fetch read is combinational
	// A word written on an edge is seen from the next cycle on
	assign inst = mem[fetch_addr];

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr_en,
	input  logic [`REG_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]   wr_data,
	input  logic [`REG_AW-1:0] rs1_addr,
	input  logic [`REG_AW-1:0] rs2_addr,
	output logic [`XLEN-1:0]   rs1_data,
	output logic [`XLEN-1:0]   rs2_data
);

	logic [`XLEN-1:0] regs [2**`REG_AW];

	// Write from WB
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**`REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin     // x0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	// Same-cycle WB write is not seen here
	// The hazard unit covers it by forwarding from WB
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f verilog.f -o tb_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

/* rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define PC_W        12          // Byte address with 4 KiB reach
`define REG_AW      5

// Instruction memory geometry
`define IMEM_WORDS  256
`define IMEM_AW     8           // Word address from PC bits [9:2]

// Opcodes of the supported subset
`define OP_ALU      7'b0110011
`define OP_ALUI     7'b0010011
`define OP_LUI      7'b0110111
`define OP_JAL      7'b1101111
`define OP_BRANCH   7'b1100011

// Branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101

`define NOP_INST    32'h0000_0013   // addi x0, x0, 0

`endif

/* rv_core_pkg.sv */
`default_nettype none
`include "rv_core_consts.svh"

package rv_core_pkg;

	// First member of each enum is the bubble value
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
	} alu_op_e;

	typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_kind_e;

	typedef enum logic [1:0] {FWD_RF, FWD_EXE, FWD_MEM, FWD_WB} fwd_sel_e;

	// Next PC source
	typedef enum logic [1:0] {PC_HOLD, PC_PLUS4, PC_JUMP, PC_BRANCH} pc_sel_e;

	typedef struct packed {
		alu_op_e  alu_op;
		logic     use_imm_b;    // Immediate replaces rs2 as operand B
		logic     wr_en;
		wb_sel_e  wb_sel;
		br_kind_e br_kind;
		logic     is_jump;      // JAL
		logic     uses_rs1;
		logic     uses_rs2;
	} ctrl_t;

	typedef struct packed {
		logic               valid;
		logic [`PC_W-1:0]   pc;
		logic [`XLEN-1:0]   inst;
	} if_id_t;

	typedef struct packed {
		logic               valid;
		logic [`PC_W-1:0]   pc;
		logic [`PC_W-1:0]   pc4;
		logic [`REG_AW-1:0] rd;
		ctrl_t              ctrl;
		logic [`XLEN-1:0]   op_a;           // Already forwarded in ID
		logic [`XLEN-1:0]   op_b;
		logic [`XLEN-1:0]   rs2_val;        // Second compare operand of a branch
		logic [`PC_W-1:0]   branch_target;
	} id_exe_t;

	typedef struct packed {
		logic               valid;
		logic [`REG_AW-1:0] rd;
		logic               wr_en;
		wb_sel_e            wb_sel;
		logic [`XLEN-1:0]   alu_res;
		logic [`PC_W-1:0]   pc4;
	} exe_mem_t;

	typedef exe_mem_t mem_wb_t;     // Nothing changes in MEM without loads

	typedef struct packed {
		logic               valid;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   data;
		logic [`PC_W-1:0]   pc;
	} retire_t;

endpackage

`default_nettype wire

/* stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

// One pipeline register for all four stage boundaries
module stage_reg #(
	parameter type payload_t = rv_core_pkg::if_id_t
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,     // Load a bubble instead of d
	input  payload_t d,
	output payload_t q
);

	// Only valid is cleared, so a bubble keeps stale data
	always_ff @(posedge clk) begin
		q <= d;
		if (!rst_n || flush) begin
			q.valid <= 1'b0;    // Reset looks like a flush
		end
	end

endmodule

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_consts.svh"

module tb_core;
	import rv_core_pkg::*;

	localparam int DRAIN = 8;      // Pipeline depth plus margin

	logic                clk;
	logic                rst_n;
	logic                run;
	logic                prog_we;
	logic [`IMEM_AW-1:0] prog_addr;
	logic [`XLEN-1:0]    prog_data;
	retire_t             retire;

	// Golden contents
	logic [`IMEM_AW-1:0] p_addr [$];
	logic [`XLEN-1:0]    p_word [$];
	logic [`REG_AW-1:0]  e_rd [$];
	logic [`XLEN-1:0]    e_data [$];
	logic [`PC_W-1:0]    e_pc [$];
	int                  e_grp [$];     // Test group of each record
	string               g_name [$];
	int                  g_first [$];
	int                  g_last [$];    // Index of the group's final record
	int                  g_err [$];

	int n_seen = 0;     // Retires checked so far
	int cycles = 0;
	int load_err = 0;
	int idle_err = 0;
	int extra_err = 0;
	int n_pass = 0;
	int n_fail = 0;
	bit timed_out = 1'b0;

	core dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.retire    (retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// Drop newline and trailing blanks
	function automatic string trim_end(input string s);
		string r;
		r = s;
		while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d
			|| r.getc(r.len() - 1) == 8'h20)) begin
			r = r.substr(0, r.len() - 2);
		end
		return r;
	endfunction

	task automatic load_golden();
		int          fd;
		int          got;
		int          need;
		byte         tag;
		string       line;
		logic [31:0] f1, f2, f3;
		fd = $fopen("core_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open core_golden.txt");
			load_err++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			line = trim_end(line);
			tag  = (line.len() > 0) ? line.getc(0) : 8'h23;    // Blank reads as comment
			got  = 0;
			need = 0;
			if (tag == 8'h50) begin         // P addr word
				need = 2;
				got  = $sscanf(line, "P %h %h", f1, f2);
				p_addr.push_back(f1[`IMEM_AW-1:0]);
				p_word.push_back(f2);
			end else if (tag == 8'h54) begin        // T name
				g_name.push_back(line.substr(2, line.len() - 1));
				g_first.push_back(e_rd.size());
				g_last.push_back(-1);
				g_err.push_back(0);
			end else if (tag == 8'h52) begin        // R rd data pc
				need = 3;
				got  = (g_name.size() > 0) ? $sscanf(line, "R %h %h %h", f1, f2, f3) : 0;
				e_rd.push_back(f1[`REG_AW-1:0]);
				e_data.push_back(f2);
				e_pc.push_back(f3[`PC_W-1:0]);
				e_grp.push_back(g_name.size() - 1);
				if (g_name.size() > 0) g_last[g_last.size() - 1] = e_rd.size() - 1;
			end
			if (got != need) begin
				$display("Malformed golden line: %s", line);
				load_err++;
			end
		end
		$fclose(fd);
	endtask

	task automatic report_group(input int g, input int missing);
		if (g_err[g] == 0 && missing == 0) begin
			$display("Test %s: pass, %0d retires", g_name[g], g_last[g] - g_first[g] + 1);
			n_pass++;
		end else begin
			$display("Test %s: FAIL, %0d wrong fields, %0d retires missing",
				g_name[g], g_err[g], missing);
			n_fail++;
		end
	endtask

	// Compare one retire with record i
	task automatic check_retire(input int i);
		int g;
		g = e_grp[i];
		if (retire.rd !== e_rd[i]) begin
			$display("** Error %0t: rd expected x%0d got x%0d", $time, e_rd[i], retire.rd);
			g_err[g]++;
		end
		if (retire.data !== e_data[i]) begin
			$display("** Error %0t: data expected %h got %h", $time, e_data[i], retire.data);
			g_err[g]++;
		end
		if (retire.pc !== e_pc[i]) begin
			$display("** Error %0t: pc expected %h got %h", $time, e_pc[i], retire.pc);
			g_err[g]++;
		end
		if (i == g_last[g]) report_group(g, 0);    // Group done
	endtask

	// Retire port sampled away from the rising edge
	always @(negedge clk) begin
		if (rst_n && retire.valid) begin
			if (!run) begin
				$display("Retire of x%0d seen while run is low", retire.rd);
				idle_err++;
			end else if (n_seen >= e_rd.size()) begin
				$display("Unexpected retire of x%0d at pc %h", retire.rd, retire.pc);
				extra_err++;
			end else begin
				check_retire(n_seen);
				n_seen++;
			end
		end
	end

	task automatic load_program();
		for (int i = 0; i < p_word.size(); i++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= p_addr[i];
			prog_data <= p_word[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;    // Last word lands on this edge
	endtask

	initial begin
		int limit;
		int missing;
		rst_n     = 1'b0;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		$timeformat(-9, 1, " ns", 10);
		load_golden();
		limit = 3 + p_word.size() + 4 * p_word.size() + 64;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		if (load_err == 0 && e_rd.size() > 0) begin
			load_program();
			if (idle_err == 0) begin
				$display("Test idle: pass, no retire while run is low");
				n_pass++;
			end else begin
				$display("Test idle: FAIL, %0d retires while run is low", idle_err);
				n_fail++;
			end
			run <= 1'b1;
			while (n_seen < e_rd.size() && cycles < limit) begin
				@(posedge clk);
			end
			if (n_seen < e_rd.size()) begin
				timed_out = 1'b1;
				$display("Timeout after %0d cycles with %0d of %0d retires seen",
					cycles, n_seen, e_rd.size());
			end else begin
				repeat (DRAIN) @(posedge clk);     // Late extra retires
			end
			// Groups cut short by missing retires
			for (int g = 0; g < g_name.size(); g++) begin
				if (g_last[g] >= n_seen) begin
					missing = g_last[g] - ((n_seen > g_first[g]) ? n_seen : g_first[g]) + 1;
					report_group(g, missing);
				end
			end
		end else begin
			$display("Golden file gave no usable records");
			load_err++;
		end
		$display("Tests passed %0d, failed %0d, retires %0d of %0d, extra %0d",
			n_pass, n_fail, n_seen, e_rd.size(), extra_err);
		if (n_fail == 0 && load_err == 0 && extra_err == 0 && !timed_out) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
rv_core_pkg.sv
stage_reg.sv
instmem.sv
decoder.sv
regfile.sv
alu.sv
hazard_unit.sv
core.sv
tb_core.sv
